//--- hdl/mcu_cmd_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transaction start detection and first-nibble command decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_cmd_decoder
#(
    parameter ncu_mcu_pkg::link_dir_e DIR = ncu_mcu_pkg::DIR_DOWN
)
(
    input  logic                      iol2clk,
    input  logic                      rst_n,
    input  ncu_mcu_pkg::mcu_link_t    link,
    output ncu_mcu_pkg::mcu_cmd_evt_t cmd
);

    import ncu_mcu_pkg::*;

    logic        vld_q;
    logic        start;
    logic        known_d;
    mcu_nibble_u nib_u;
    logic        valid_q;
    logic        known_q;
    mcu_nibble_u code_q;

    // Rising edge of valid, stall does not matter here
    assign start = link.vld && !vld_q;

    always_comb
    begin
        nib_u   = link.data;
        known_d = 1'b0;
        if (DIR == DIR_DOWN)
        begin
            case (nib_u.down)
                READ_REQ, WRITE_REQ, IFILL_REQ: known_d = 1'b1;
                default: known_d = 1'b0;
            endcase
        end
        else
        begin
            case (nib_u.up)
                READ_NACK, READ_ACK, IFILL_ACK, IFILL_NACK, INT, INT_VEC: known_d = 1'b1;
                default: known_d = 1'b0;
            endcase
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            vld_q   <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            vld_q   <= link.vld;
            valid_q <= start;
        end
    end

    // Code and flag are only meaningful alongside valid
    always_ff @(posedge iol2clk)
    begin
        if (start)
        begin
            code_q  <= nib_u;
            known_q <= known_d;
        end
    end

    assign cmd.valid = valid_q;
    assign cmd.known = known_q;
    assign cmd.code  = code_q;

endmodule

`default_nettype wire

//--- hdl/mcu_link_assembler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nibble counter and 128-bit packet assembly with done
// and runt pulses for one link direction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_link_assembler
(
    input  logic                      iol2clk,
    input  logic                      rst_n,
    input  ncu_mcu_pkg::mcu_link_t    link,
    output ncu_mcu_pkg::mcu_pkt_evt_t pkt
);

    import ncu_mcu_pkg::*;

    localparam int CNT_W = $clog2(NIBBLES_PER_PKT + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(NIBBLES_PER_PKT);

    logic [CNT_W-1:0] nib_cnt;
    logic [PKT_W-1:0] asm_buf;
    logic [PKT_W-1:0] pkt_data_q;
    logic             done_q;
    logic             runt_q;
    logic             accept;

    // A nibble only counts while valid, unstalled and the packet still has room
    assign accept = link.vld && !link.stall && (nib_cnt < FULL_CNT);

    // Working buffer, least significant nibble arrives first
    always_ff @(posedge iol2clk)
    begin
        if (accept)
        begin
            asm_buf[nib_cnt[CNT_W-2:0] * NIBBLE_W +: NIBBLE_W] <= link.data;
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            nib_cnt    <= '0;
            done_q     <= 1'b0;
            runt_q     <= 1'b0;
            pkt_data_q <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            runt_q <= 1'b0;
            if (accept)
            begin
                nib_cnt <= nib_cnt + 1'b1;
            end
            else if (!link.vld)
            begin
                // End of transaction, a short one is reported as a runt
                nib_cnt <= '0;
                if (nib_cnt == FULL_CNT)
                begin
                    done_q     <= 1'b1;
                    pkt_data_q <= asm_buf;
                end
                else if (nib_cnt != '0)
                begin
                    runt_q <= 1'b1;
                end
            end
        end
    end

    assign pkt.done = done_q;
    assign pkt.runt = runt_q;
    assign pkt.data = pkt_data_q;

endmodule

`default_nettype wire

//--- hdl/mcu_link_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One direction of the NCU/MCU link: assembler, decoder,
// stall assertion counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mcu_link_monitor
#(
    parameter ncu_mcu_pkg::link_dir_e DIR = ncu_mcu_pkg::DIR_DOWN
)
(
    input  logic                                iol2clk,
    input  logic                                rst_n,
    input  ncu_mcu_pkg::mcu_link_t              link,
    output ncu_mcu_pkg::mcu_pkt_evt_t           pkt,
    output ncu_mcu_pkg::mcu_cmd_evt_t           cmd,
    output logic [ncu_mcu_pkg::STALL_CNT_W-1:0] stall_count
);

    logic stall_q;

    mcu_link_assembler u_assembler
    (
        .iol2clk (iol2clk),
        .rst_n   (rst_n),
        .link    (link),
        .pkt     (pkt)
    );

    mcu_cmd_decoder #(.DIR(DIR)) u_decoder
    (
        .iol2clk (iol2clk),
        .rst_n   (rst_n),
        .link    (link),
        .cmd     (cmd)
    );

    // Count each new stall assertion, holding at the top value
    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            stall_q     <= 1'b0;
            stall_count <= '0;
        end
        else
        begin
            stall_q <= link.stall;
            if (link.stall && !stall_q && (stall_count != '1))
            begin
                stall_count <= stall_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ncu_mcu_mon_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCU/MCU link monitor top, downstream and upstream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module ncu_mcu_mon_top
(
    input  logic                                iol2clk,
    input  logic                                rst_n,
    input  ncu_mcu_pkg::mcu_link_t              down_link,
    input  ncu_mcu_pkg::mcu_link_t              up_link,
    output ncu_mcu_pkg::mcu_pkt_evt_t           down_pkt,
    output ncu_mcu_pkg::mcu_pkt_evt_t           up_pkt,
    output ncu_mcu_pkg::mcu_cmd_evt_t           down_cmd,
    output ncu_mcu_pkg::mcu_cmd_evt_t           up_cmd,
    output logic [ncu_mcu_pkg::STALL_CNT_W-1:0] down_stall_count,
    output logic [ncu_mcu_pkg::STALL_CNT_W-1:0] up_stall_count
);

    import ncu_mcu_pkg::*;

    // NCU to MCU requests
    mcu_link_monitor #(.DIR(DIR_DOWN)) u_down
    (
        .iol2clk     (iol2clk),
        .rst_n       (rst_n),
        .link        (down_link),
        .pkt         (down_pkt),
        .cmd         (down_cmd),
        .stall_count (down_stall_count)
    );

    // MCU to NCU responses
    mcu_link_monitor #(.DIR(DIR_UP)) u_up
    (
        .iol2clk     (iol2clk),
        .rst_n       (rst_n),
        .link        (up_link),
        .pkt         (up_pkt),
        .cmd         (up_cmd),
        .stall_count (up_stall_count)
    );

endmodule

`default_nettype wire

//--- hdl/ncu_mcu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCU/MCU link monitor package: widths, command codes,
// the first-nibble union and the link and event structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package ncu_mcu_pkg;

    localparam int NIBBLE_W        = 4;
    localparam int NIBBLES_PER_PKT = 32;
    localparam int PKT_W           = NIBBLE_W * NIBBLES_PER_PKT;
    localparam int STALL_CNT_W     = 8;

    typedef enum logic
    {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } link_dir_e;

    // NCU to MCU request codes
    typedef enum logic [NIBBLE_W-1:0]
    {
        READ_REQ  = 4'b0100,
        WRITE_REQ = 4'b0101,
        IFILL_REQ = 4'b0110
    } down_cmd_e;

    // MCU to NCU response codes
    typedef enum logic [NIBBLE_W-1:0]
    {
        READ_NACK  = 4'b0000,
        READ_ACK   = 4'b0001,
        IFILL_ACK  = 4'b0011,
        IFILL_NACK = 4'b0111,
        INT        = 4'b1000,
        INT_VEC    = 4'b1100
    } up_cmd_e;

    // The first nibble means a request downstream and a response upstream
    typedef union packed
    {
        down_cmd_e down;
        up_cmd_e   up;
    } mcu_nibble_u;

    typedef struct packed
    {
        logic                vld;
        logic                stall;
        logic [NIBBLE_W-1:0] data;
    } mcu_link_t;

    typedef struct packed
    {
        logic             done;
        logic             runt;
        logic [PKT_W-1:0] data;
    } mcu_pkt_evt_t;

    typedef struct packed
    {
        logic        valid;
        logic        known;
        mcu_nibble_u code;
    } mcu_cmd_evt_t;

endpackage

`default_nettype wire

//--- project.f
hdl/ncu_mcu_pkg.sv
hdl/mcu_link_assembler.sv
hdl/mcu_cmd_decoder.sv
hdl/mcu_link_monitor.sv
hdl/ncu_mcu_mon_top.sv
sim/ncu_mcu_mon_props.sv
sim/ncu_mcu_mon_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the link monitor testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f project.f \
    --top-module ncu_mcu_mon_tb \
    -o ncu_mcu_mon_sim

./obj_dir/ncu_mcu_mon_sim | tee sim.log

grep -q "Simulation passed" sim.log
echo "run_sim.sh: pass found in sim.log"

//--- sim/ncu_mcu_mon_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link monitor assertions and their bind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module ncu_mcu_mon_props
(
    input logic                                iol2clk,
    input logic                                rst_n,
    input ncu_mcu_pkg::mcu_pkt_evt_t           pkt,
    input ncu_mcu_pkg::mcu_cmd_evt_t           cmd,
    input logic [ncu_mcu_pkg::STALL_CNT_W-1:0] stall_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // A transaction ends either complete or short, never both
    done_runt_exclusive: assert property (@(posedge iol2clk) disable iff (!rst_n)
        !(pkt.done && pkt.runt))
        else $error("done and runt are high in the same cycle");

    cmd_valid_single: assert property (@(posedge iol2clk) disable iff (!rst_n)
        cmd.valid |=> !cmd.valid)
        else $error("cmd valid is high on two cycles in a row");

    // Saturating counter, so it only ever holds or grows
    stall_count_monotonic: assert property (@(posedge iol2clk) disable iff (!rst_n)
        stall_count >= $past(stall_count))
        else $error("stall count decreased");

endmodule

bind mcu_link_monitor ncu_mcu_mon_props u_props
(
    .iol2clk     (iol2clk),
    .rst_n       (rst_n),
    .pkt         (pkt),
    .cmd         (cmd),
    .stall_count (stall_count)
);

`default_nettype wire

//--- sim/ncu_mcu_mon_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the NCU/MCU link monitor with a transaction table,
// a checker task, a stall pulse phase and a cycle timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module ncu_mcu_mon_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ncu_mcu_pkg::*;

    localparam int CHK_W = PKT_W + 2;

    // One row of the transaction table
    typedef struct packed
    {
        link_dir_e  dir;
        logic [3:0] first;
        logic [7:0] n_nib;
        logic       stalls;
        logic       exp_known;
        logic       exp_done;
        logic       exp_runt;
    } txn_t;

    logic                   iol2clk;
    logic                   rst_n;
    mcu_link_t              down_link;
    mcu_link_t              up_link;
    mcu_pkt_evt_t           down_pkt;
    mcu_pkt_evt_t           up_pkt;
    mcu_cmd_evt_t           down_cmd;
    mcu_cmd_evt_t           up_cmd;
    logic [STALL_CNT_W-1:0] down_stall_count;
    logic [STALL_CNT_W-1:0] up_stall_count;

    txn_t                   tbl[$];
    int                     seed;
    int                     cycles = 0;
    int                     cycle_limit;
    logic [STALL_CNT_W-1:0] exp_stalls [2];
    logic                   prev_stall [2];

    ncu_mcu_mon_top u_dut
    (
        .iol2clk          (iol2clk),
        .rst_n            (rst_n),
        .down_link        (down_link),
        .up_link          (up_link),
        .down_pkt         (down_pkt),
        .up_pkt           (up_pkt),
        .down_cmd         (down_cmd),
        .up_cmd           (up_cmd),
        .down_stall_count (down_stall_count),
        .up_stall_count   (up_stall_count)
    );

    always #10 iol2clk = ~iol2clk;

    always @(posedge iol2clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [CHK_W-1:0] exp_val,
                               input logic [CHK_W-1:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("FAIL %s: expected %0h, actual %0h", name, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic tick();
        @(posedge iol2clk);
        @(negedge iol2clk);
    endtask

    function automatic mcu_pkt_evt_t pkt_of(input link_dir_e dir);
        return (dir == DIR_DOWN) ? down_pkt : up_pkt;
    endfunction

    function automatic mcu_cmd_evt_t cmd_of(input link_dir_e dir);
        return (dir == DIR_DOWN) ? down_cmd : up_cmd;
    endfunction

    // Drives one direction and tracks the stall rising edges it creates
    task automatic drive_link(input link_dir_e dir, input logic vld, input logic stall,
                              input logic [3:0] data);
        mcu_link_t lnk;
        lnk.vld   = vld;
        lnk.stall = stall;
        lnk.data  = data;
        if (stall && !prev_stall[dir] && (exp_stalls[dir] != '1))
        begin
            exp_stalls[dir] = exp_stalls[dir] + 1'b1;
        end
        prev_stall[dir] = stall;
        if (dir == DIR_DOWN)
        begin
            down_link = lnk;
        end
        else
        begin
            up_link = lnk;
        end
    endtask

    task automatic check_stall_counts(input string tag);
        check_value({tag, " down stall count"}, CHK_W'(exp_stalls[0]), CHK_W'(down_stall_count));
        check_value({tag, " up stall count"}, CHK_W'(exp_stalls[1]), CHK_W'(up_stall_count));
    endtask

    task automatic check_outputs(input string tag, input link_dir_e dir, input logic exp_valid,
                                 input logic exp_done, input logic exp_runt);
        link_dir_e    other;
        mcu_pkt_evt_t p;
        mcu_cmd_evt_t c;
        mcu_pkt_evt_t q;
        mcu_cmd_evt_t d;
        other = (dir == DIR_DOWN) ? DIR_UP : DIR_DOWN;
        p = pkt_of(dir);
        c = cmd_of(dir);
        q = pkt_of(other);
        d = cmd_of(other);
        check_value({tag, " cmd valid"}, CHK_W'(exp_valid), CHK_W'(c.valid));
        check_value({tag, " done"}, CHK_W'(exp_done), CHK_W'(p.done));
        check_value({tag, " runt"}, CHK_W'(exp_runt), CHK_W'(p.runt));
        // The quiet direction must stay silent
        check_value({tag, " idle side pulses"}, '0, CHK_W'({q.done, q.runt, d.valid}));
        check_stall_counts(tag);
    endtask

    task automatic run_entry(input int idx);
        txn_t             t;
        string            tag;
        logic [PKT_W-1:0] exp_data;
        logic [PKT_W-1:0] old_data;
        logic [3:0]       nib;
        logic             stall;
        int               taken;
        mcu_pkt_evt_t     p;
        mcu_cmd_evt_t     c;
        t        = tbl[idx];
        tag      = $sformatf("entry %0d", idx);
        exp_data = '0;
        p        = pkt_of(t.dir);
        old_data = p.data;

        // The command nibble is also packet nibble 0
        drive_link(t.dir, 1'b1, 1'b0, t.first);
        exp_data[3:0] = t.first;
        taken = 1;
        tick();
        check_outputs({tag, " start"}, t.dir, 1'b1, 1'b0, 1'b0);
        c = cmd_of(t.dir);
        check_value({tag, " code"}, CHK_W'(t.first), CHK_W'(c.code));
        check_value({tag, " known"}, CHK_W'(t.exp_known), CHK_W'(c.known));

        while (taken < int'(t.n_nib))
        begin
            nib   = 4'($random(seed));
            stall = t.stalls && (($random(seed) & 3) == 0);
            drive_link(t.dir, 1'b1, stall, nib);
            if (!stall)
            begin
                if (taken < NIBBLES_PER_PKT)
                begin
                    exp_data[taken*NIBBLE_W +: NIBBLE_W] = nib;
                end
                taken++;
            end
            tick();
            check_outputs({tag, " body"}, t.dir, 1'b0, 1'b0, 1'b0);
        end

        drive_link(t.dir, 1'b0, 1'b0, 4'h0);
        tick();
        check_outputs({tag, " end"}, t.dir, 1'b0, t.exp_done, t.exp_runt);
        p = pkt_of(t.dir);
        if (t.exp_done)
        begin
            check_value({tag, " packet"}, CHK_W'(exp_data), CHK_W'(p.data));
        end
        else
        begin
            check_value({tag, " held packet"}, CHK_W'(old_data), CHK_W'(p.data));
        end
        tick();
        check_outputs({tag, " idle"}, t.dir, 1'b0, 1'b0, 1'b0);
    endtask

    // Random stall levels on both directions at once while valid stays low
    task automatic pulse_stalls(input int n_cycles);
        logic s_down;
        logic s_up;
        for (int i = 0; i < n_cycles; i++)
        begin
            s_down = 1'($random(seed));
            s_up   = 1'($random(seed));
            drive_link(DIR_DOWN, 1'b0, s_down, 4'h0);
            drive_link(DIR_UP, 1'b0, s_up, 4'h0);
            tick();
            check_value("stall phase pulses", '0,
                        CHK_W'({down_pkt.done, down_pkt.runt, down_cmd.valid,
                                up_pkt.done, up_pkt.runt, up_cmd.valid}));
            check_stall_counts("stall phase");
        end
    endtask

    task automatic build_table();
        //                   dir       first  nibbles stalls known  done   runt
        tbl.push_back(txn_t'{DIR_DOWN, 4'h4, 8'd32, 1'b1, 1'b1, 1'b1, 1'b0});
        tbl.push_back(txn_t'{DIR_DOWN, 4'h5, 8'd1,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_DOWN, 4'h6, 8'd3,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_DOWN, 4'h3, 8'd1,  1'b0, 1'b0, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_UP,   4'h0, 8'd1,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_UP,   4'h1, 8'd2,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_UP,   4'h3, 8'd1,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_UP,   4'h7, 8'd1,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_UP,   4'h8, 8'd1,  1'b0, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_UP,   4'hc, 8'd32, 1'b1, 1'b1, 1'b1, 1'b0});
        tbl.push_back(txn_t'{DIR_UP,   4'h2, 8'd1,  1'b0, 1'b0, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_DOWN, 4'h4, 8'd10, 1'b1, 1'b1, 1'b0, 1'b1});
        tbl.push_back(txn_t'{DIR_DOWN, 4'h5, 8'd32, 1'b1, 1'b1, 1'b1, 1'b0});
        // Nibbles past the 32nd are dropped
        tbl.push_back(txn_t'{DIR_UP,   4'h1, 8'd35, 1'b0, 1'b1, 1'b1, 1'b0});
    endtask

    initial
    begin
        seed          = 32'h52d6_4be1;
        iol2clk       = 1'b0;
        rst_n         = 1'b0;
        down_link     = '0;
        up_link       = '0;
        exp_stalls[0] = '0;
        exp_stalls[1] = '0;
        prev_stall[0] = 1'b0;
        prev_stall[1] = 1'b0;
        build_table();

        // Stalls can stretch a transaction, so each nibble gets two cycles
        cycle_limit = 5 + 16 + 50;
        foreach (tbl[i])
        begin
            cycle_limit = cycle_limit + 2 * int'(tbl[i].n_nib) + 4;
        end

        repeat (5) @(posedge iol2clk);
        @(negedge iol2clk);
        check_value("reset down packet", '0, CHK_W'(down_pkt));
        check_value("reset up packet", '0, CHK_W'(up_pkt));
        check_value("reset cmd valid", '0, CHK_W'({down_cmd.valid, up_cmd.valid}));
        check_stall_counts("reset");
        rst_n = 1'b1;
        tick();

        for (int i = 0; i < tbl.size(); i++)
        begin
            run_entry(i);
        end
        pulse_stalls(16);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
